// File: aesPadGen.f
logic/aesPkg.sv
logic/seedKeyJoin.sv
logic/aesRound.sv
logic/aesCore.sv
logic/padValidLine.sv
logic/aesPadGen.sv
test/aesPadGen_checker.sv
test/aesPadGenTb.sv

// File: logic/aesCore.sv
/* Fully pipelined AES-128 encryption, one block per cycle.
   Initial key-add stage, then ten round stages, 11 cycles in all */
`timescale 1ns/1ps

module aesCore (
   input  logic            clock,
   input  aesPkg::aesBlock plain,
   input  aesPkg::aesBlock key,
   output aesPkg::aesBlock cipher
);
   import aesPkg::*;

   // Stage s holds the state after round s
   aesBlock stState [0:10];
   // Final round key is never needed downstream
   aesBlock stKey [0:9];

   // Round 0, plain AddRoundKey with the cipher key
   always_ff @(posedge clock) begin
      stState[0] <= plain ^ key;
      stKey[0]   <= key;
   end

   for (genvar r = 1; r <= 10; r++) begin : rounds
      if (r < 10) begin : mid
         aesRound #(.round(r)) roundStage (
            .clock    (clock),
            .inState  (stState[r-1]),
            .inKey    (stKey[r-1]),
            .outState (stState[r]),
            .outKey   (stKey[r])
         );
      end else begin : last
         aesRound #(.round(r)) roundStage (
            .clock    (clock),
            .inState  (stState[r-1]),
            .inKey    (stKey[r-1]),
            .outState (stState[r]),
            .outKey   ()
         );
      end
   end

   assign cipher = stState[10];

endmodule

// File: logic/aesPadGen.sv
/* Counter-mode pad generator top. One seed and key pair yields padLanes
   AES-128 blocks on seed+k, lane 0 in the low bits, padLatency cycles later */
`timescale 1ns/1ps

module aesPadGen (
   input  logic                         clock,
   input  logic                         rst,
   input  logic [aesPkg::seedWidth-1:0] seed,
   input  logic                         seedValid,
   output logic                         seedReady,
   input  aesPkg::aesBlock              key,
   input  logic                         keyValid,
   output logic                         keyReady,
   output aesPkg::padWord               pad,
   output logic                         padValid
);
   import aesPkg::*;

   logic [seedWidth-1:0] seedReg;
   aesBlock              keyReg;
   logic                 go;

   // ------------------------------
   // Input pairing
   // ------------------------------
   seedKeyJoin pairJoin (
      .clock     (clock),
      .rst       (rst),
      .seed      (seed),
      .seedValid (seedValid),
      .seedReady (seedReady),
      .key       (key),
      .keyValid  (keyValid),
      .keyReady  (keyReady),
      .seedReg   (seedReg),
      .keyReg    (keyReg),
      .go        (go)
   );

   // ------------------------------
   // Lane cores
   // ------------------------------
   for (genvar k = 0; k < padLanes; k++) begin : lanes
      logic [seedWidth-1:0] laneSeed;
      aesBlock              laneCipher;

      // Counter wraps within the seed width
      assign laneSeed = seedReg + seedWidth'(k);

      aesCore laneCore (
         .clock  (clock),
         .plain  ({{(aesWidth-seedWidth){1'b0}}, laneSeed}),
         .key    (keyReg),
         .cipher (laneCipher)
      );

      assign pad[k*aesWidth +: aesWidth] = laneCipher;
   end

   // Valid rides alongside the lanes, no per-lane valids
   padValidLine validLine (
      .clock    (clock),
      .rst      (rst),
      .go       (go),
      .padValid (padValid)
   );

endmodule

// File: logic/aesPkg.sv
/* Shared widths, lane count and pipeline latencies for the AES pad generator,
   plus the GF(2^8) byte functions used by the round stages */
package aesPkg;

   // ------------------------------
   // Widths and latencies
   // ------------------------------
   localparam int aesWidth    = 128;
   localparam int seedWidth   = 64;
   localparam int padLanes    = 4;
   // Key-add stage plus ten rounds
   localparam int coreLatency = 11;
   // One more for the join register
   localparam int padLatency  = coreLatency + 1;

   typedef logic [aesWidth-1:0]          aesBlock;
   typedef logic [padLanes*aesWidth-1:0] padWord;

   // ------------------------------
   // GF(2^8) arithmetic
   // ------------------------------

   // Multiply by x, reduced by the AES polynomial
   function automatic logic [7:0] xtime(input logic [7:0] a);
      return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
   endfunction

   // Shift-and-add product
   function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
      logic [7:0] acc;
      logic [7:0] term;
      acc  = 8'h00;
      term = a;
      for (int i = 0; i < 8; i++) begin
         if (b[i]) begin
            acc = acc ^ term;
         end
         term = xtime(term);
      end
      return acc;
   endfunction

   // Inverse as a^254, built from the squares a^2 .. a^128
   // Zero maps to zero, as the S-box needs
   function automatic logic [7:0] gfInv(input logic [7:0] a);
      logic [7:0] sq;
      logic [7:0] inv;
      sq  = a;
      inv = 8'h01;
      for (int i = 1; i < 8; i++) begin
         sq  = gfMul(sq, sq);
         inv = gfMul(inv, sq);
      end
      return inv;
   endfunction

   // S-box: field inverse then the affine map with constant 0x63
   function automatic logic [7:0] sbox(input logic [7:0] x);
      logic [7:0] v;
      v = gfInv(x);
      return v ^ {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^ {v[4:0], v[7:5]}
             ^ {v[3:0], v[7:4]} ^ 8'h63;
   endfunction

   // Round constant, x^(r-1) for r from 1 to 10
   function automatic logic [7:0] rcon(input int r);
      logic [7:0] c;
      c = 8'h01;
      for (int i = 1; i < 10; i++) begin
         if (i < r) begin
            c = xtime(c);
         end
      end
      return c;
   endfunction

endpackage

// File: logic/aesRound.sv
/* One registered AES-128 encryption round with its key schedule step.
   Chained ten deep inside aesCore, one instance per round number */
`timescale 1ns/1ps

module aesRound #(
   parameter int round = 1
) (
   input  logic            clock,
   input  aesPkg::aesBlock inState,
   input  aesPkg::aesBlock inKey,
   output aesPkg::aesBlock outState,
   output aesPkg::aesBlock outKey
);
   import aesPkg::*;

   aesBlock nextKey;
   aesBlock nextState;

   // ------------------------------
   // Key expansion
   // ------------------------------
   always_comb begin
      logic [31:0] w0;
      logic [31:0] w1;
      logic [31:0] w2;
      logic [31:0] w3;
      logic [31:0] t;
      w0 = inKey[127:96];
      w1 = inKey[95:64];
      w2 = inKey[63:32];
      w3 = inKey[31:0];
      // RotWord, SubWord, then rcon into the top byte
      t  = {sbox(w3[23:16]), sbox(w3[15:8]), sbox(w3[7:0]), sbox(w3[31:24])};
      t  = t ^ {rcon(round), 24'h000000};
      w0 = w0 ^ t;
      w1 = w1 ^ w0;
      w2 = w2 ^ w1;
      w3 = w3 ^ w2;
      nextKey = {w0, w1, w2, w3};
   end

   // ------------------------------
   // State transform
   // ------------------------------
   // Byte i of the block is bits [127-8i -: 8], column-major
   always_comb begin
      logic [7:0] sb [16];
      logic [7:0] sr [16];
      logic [7:0] a0;
      logic [7:0] a1;
      logic [7:0] a2;
      logic [7:0] a3;
      for (int i = 0; i < 16; i++) begin
         sb[i] = sbox(inState[127-8*i -: 8]);
      end
      // Row r rotates left by r columns
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            sr[4*c+r] = sb[4*((c+r)%4)+r];
         end
      end
      for (int c = 0; c < 4; c++) begin
         a0 = sr[4*c];
         a1 = sr[4*c+1];
         a2 = sr[4*c+2];
         a3 = sr[4*c+3];
         if (round != 10) begin
            // MixColumns, 3a written as xtime(a) ^ a
            sr[4*c]   = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            sr[4*c+1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            sr[4*c+2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            sr[4*c+3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
         end
      end
      for (int i = 0; i < 16; i++) begin
         nextState[127-8*i -: 8] = sr[i] ^ nextKey[127-8*i -: 8];
      end
   end

   always_ff @(posedge clock) begin
      outState <= nextState;
      outKey   <= nextKey;
   end

endmodule

// File: logic/padValidLine.sv
/* Output valid for the pad. Delays the join strobe by the core latency
   so it lines up with the lane results */
`timescale 1ns/1ps

module padValidLine (
   input  logic clock,
   input  logic rst,
   input  logic go,
   output logic padValid
);
   import aesPkg::*;

   // One bit per core stage
   logic [coreLatency-1:0] line;

   always_ff @(posedge clock) begin
      if (rst) begin
         line <= '0;
      end else begin
         line <= {line[coreLatency-2:0], go};
      end
   end

   // Oldest strobe meets the final round register
   assign padValid = line[coreLatency-1];

endmodule

// File: logic/seedKeyJoin.sv
/* Input side of the pad generator. Pairs the seed and key strobes and
   holds the accepted pair for the lane cores */
`timescale 1ns/1ps

module seedKeyJoin (
   input  logic                         clock,
   input  logic                         rst,
   input  logic [aesPkg::seedWidth-1:0] seed,
   input  logic                         seedValid,
   output logic                         seedReady,
   input  aesPkg::aesBlock              key,
   input  logic                         keyValid,
   output logic                         keyReady,
   output logic [aesPkg::seedWidth-1:0] seedReg,
   output aesPkg::aesBlock              keyReg,
   output logic                         go
);
   import aesPkg::*;

   logic accept;

   // Each side is ready exactly when its partner is valid
   assign seedReady = keyValid;
   assign keyReady  = seedValid;
   assign accept    = seedValid & keyValid;

   // Payload capture, only on a joined pair
   always_ff @(posedge clock) begin
      if (accept) begin
         seedReg <= seed;
         keyReg  <= key;
      end
   end

   // One-cycle start pulse per pair
   always_ff @(posedge clock) begin
      if (rst) begin
         go <= 1'b0;
      end else begin
         go <= accept;
      end
   end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the pad generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
   --top-module aesPadGenTb -f aesPadGen.f \
   --Mdir obj_dir -o simv

./obj_dir/simv | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
   echo "Simulation ended without a verdict"
   exit 1
fi

// File: test/aesPadGenTb.sv
/* Testbench for the pad generator. Vectors come from the golden file,
   lanes are checked against a local AES-128 model */
`timescale 1ns/1ps

module aesPadGenTb;
   import aesPkg::*;

   logic                 clock = 1'b0;
   logic                 rst;
   logic [seedWidth-1:0] seed;
   logic                 seedValid;
   logic                 seedReady;
   aesBlock              key;
   logic                 keyValid;
   logic                 keyReady;
   padWord               pad;
   logic                 padValid;

   logic [7:0]           sTab [256];
   logic [15:0]          lfsrState = 16'd99;
   logic [seedWidth-1:0] vecSeed [$];
   aesBlock              vecKey [$];
   padWord               expPad [$];
   int                   idxQ [$];
   int                   cycQ [$];
   int                   nVec = 0;
   int                   curIdx = 0;
   int                   cyc = 0;
   int                   valueErrors = 0;
   int                   otherErrors = 0;
   int                   padsSeen = 0;

   localparam int maxGap = 7;

   aesPadGen i_dut (.*);

   always #2 clock = ~clock;

   // ------------------------------
   // Reference model
   // ------------------------------
   function automatic logic [7:0] fieldMul(input logic [7:0] a, input logic [7:0] b);
      logic [7:0] p;
      logic       hi;
      p = 8'h00;
      for (int i = 0; i < 8; i++) begin
         if (b[i]) p = p ^ a;
         hi = a[7];
         a  = a << 1;
         if (hi) a = a ^ 8'h1b;
      end
      return p;
   endfunction

   // Inverse by search, then the affine map bit by bit
   function automatic logic [7:0] slowSub(input logic [7:0] x);
      logic [7:0] inv;
      logic [7:0] o;
      inv = 8'h00;
      for (int y = 1; y < 256; y++) begin
         if (fieldMul(x, 8'(y)) == 8'h01) inv = 8'(y);
      end
      for (int i = 0; i < 8; i++) begin
         o[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8];
      end
      return o ^ 8'h63;
   endfunction

   function automatic aesBlock encrypt(input aesBlock pt, input aesBlock k);
      logic [7:0] rk [176];
      logic [7:0] s [16];
      logic [7:0] t [16];
      logic [7:0] tmp [4];
      logic [7:0] rc;
      aesBlock    res;
      rc = 8'h01;
      for (int i = 0; i < 16; i++) rk[i] = k[127-8*i -: 8];
      for (int i = 16; i < 176; i += 4) begin
         for (int j = 0; j < 4; j++) tmp[j] = rk[i-4+j];
         if (i % 16 == 0) begin
            tmp[0] = sTab[rk[i-3]] ^ rc;
            tmp[1] = sTab[rk[i-2]];
            tmp[2] = sTab[rk[i-1]];
            tmp[3] = sTab[rk[i-4]];
            rc = fieldMul(rc, 8'h02);
         end
         for (int j = 0; j < 4; j++) rk[i+j] = rk[i-16+j] ^ tmp[j];
      end
      for (int i = 0; i < 16; i++) s[i] = pt[127-8*i -: 8] ^ rk[i];
      for (int r = 1; r <= 10; r++) begin
         for (int i = 0; i < 16; i++) t[i] = sTab[s[i]];
         // ShiftRows into s
         for (int c = 0; c < 4; c++) begin
            for (int w = 0; w < 4; w++) s[4*c+w] = t[4*((c+w)%4)+w];
         end
         if (r < 10) begin
            for (int c = 0; c < 4; c++) begin
               for (int w = 0; w < 4; w++) begin
                  t[w] = fieldMul(s[4*c+w], 8'h02) ^ fieldMul(s[4*c+(w+1)%4], 8'h03)
                         ^ s[4*c+(w+2)%4] ^ s[4*c+(w+3)%4];
               end
               for (int w = 0; w < 4; w++) s[4*c+w] = t[w];
            end
         end
         for (int i = 0; i < 16; i++) s[i] = s[i] ^ rk[16*r+i];
      end
      for (int i = 0; i < 16; i++) res[127-8*i -: 8] = s[i];
      return res;
   endfunction

   // Galois LFSR stepped once per bit
   function automatic logic takeBit();
      logic b;
      b = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (b) lfsrState = lfsrState ^ 16'hb400;
      return b;
   endfunction

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic checkPad(input string name, input padWord got, input padWord exp);
      if (got !== exp) begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         valueErrors++;
      end
   endtask

   task automatic checkReady(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         valueErrors++;
      end
   endtask

   task automatic loadGolden();
      int                   fd;
      int                   flag;
      string                line;
      logic [seedWidth-1:0] s;
      aesBlock              k;
      aesBlock              kat;
      padWord               p;
      fd = $fopen("test/aesPadGen_golden.txt", "r");
      if (fd == 0) begin
         $display("Could not open the golden vector file");
         otherErrors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
               if ($sscanf(line, "%h %h %h %h", s, k, flag, kat) == 4) begin
                  for (int n = 0; n < padLanes; n++) begin
                     p[n*aesWidth +: aesWidth] = encrypt({64'h0, s + seedWidth'(n)}, k);
                  end
                  // Published answer overrides the model on lane 0
                  if (flag == 1) p[aesWidth-1:0] = kat;
                  vecSeed.push_back(s);
                  vecKey.push_back(k);
                  expPad.push_back(p);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // ------------------------------
   // Monitors
   // ------------------------------
   always @(posedge clock) begin
      cyc++;
      checkReady("seedReady", seedReady, keyValid);
      checkReady("keyReady", keyReady, seedValid);
      if (seedValid && keyValid && !rst) begin
         idxQ.push_back(curIdx);
         cycQ.push_back(cyc);
      end
   end

   // Registered outputs are stable at the falling edge
   always @(negedge clock) begin
      int idx;
      int acc;
      if (padValid === 1'b1) begin
         if (idxQ.size() == 0) begin
            $display("padValid rose with no accepted pair outstanding at cycle %0d", cyc);
            otherErrors++;
         end else begin
            idx = idxQ.pop_front();
            acc = cycQ.pop_front();
            padsSeen++;
            // Value seen here is the one sampled at the next rising edge
            if (cyc + 1 - acc != padLatency) begin
               $display("Pad %0d arrived %0d cycles after accept", idx, cyc + 1 - acc);
               otherErrors++;
            end
            checkPad("pad", pad, expPad[idx]);
         end
      end
   end

   // ------------------------------
   // Stimulus
   // ------------------------------
   initial begin
      int  gap;
      logic seedFirst;
      rst       = 1'b1;
      seed      = '0;
      key       = '0;
      seedValid = 1'b0;
      keyValid  = 1'b0;
      for (int i = 0; i < 256; i++) sTab[i] = slowSub(8'(i));
      loadGolden();
      nVec = vecSeed.size();
      repeat (16) @(posedge clock);
      @(negedge clock);
      rst = 1'b0;
      repeat (padLatency) @(negedge clock);

      // Handshake phase where one side leads by a cycle
      for (int i = 0; i < nVec / 2; i++) begin
         gap = {takeBit(), takeBit(), takeBit()};
         seedFirst = takeBit();
         repeat (gap) @(negedge clock);
         seed = vecSeed[i];
         key  = vecKey[i];
         curIdx = i;
         if (seedFirst) seedValid = 1'b1;
         else keyValid = 1'b1;
         @(negedge clock);
         seedValid = 1'b1;
         keyValid  = 1'b1;
         @(negedge clock);
         seedValid = 1'b0;
         keyValid  = 1'b0;
      end

      // Back-to-back phase
      for (int i = nVec / 2; i < nVec; i++) begin
         seed = vecSeed[i];
         key  = vecKey[i];
         curIdx = i;
         seedValid = 1'b1;
         keyValid  = 1'b1;
         @(negedge clock);
      end
      seedValid = 1'b0;
      keyValid  = 1'b0;

      while (idxQ.size() != 0) @(negedge clock);
      repeat (padLatency + 2) @(negedge clock);
      $display("Errors: %0d value, %0d other; pads checked %0d of %0d",
               valueErrors, otherErrors, padsSeen, nVec);
      if (valueErrors == 0 && otherErrors == 0 && nVec > 0 && padsSeen == nVec) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Watchdog sized from the vector count
   initial begin
      wait (nVec > 0);
      repeat (16 + nVec * (maxGap + 2) + padLatency + 50) @(posedge clock);
      $display("Timeout, the run did not finish in the expected number of cycles");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: test/aesPadGen_checker.sv
/* Handshake and timing assertions for the pad generator, bound into aesPadGen */
`timescale 1ns/1ps

module aesPadGen_checker (
   input logic           clock,
   input logic           rst,
   input logic           seedValid,
   input logic           seedReady,
   input logic           keyValid,
   input logic           keyReady,
   input aesPkg::padWord pad,
   input logic           padValid
);
   import aesPkg::*;

   // No pad while in reset, nor in the first pipeline-length after it
   assert property (@(posedge clock) rst && $past(rst) |-> !padValid) else $error("padValid in reset");
   assert property (@(posedge clock) $fell(rst) |-> !padValid [*padLatency])
      else $error("padValid too soon after reset");

   // Accept and pad valid line up exactly
   assert property (@(posedge clock) disable iff (rst)
      seedValid && keyValid |-> ##padLatency padValid) else $error("missing padValid");
   assert property (@(posedge clock) disable iff (rst)
      padValid |-> $past(seedValid && keyValid, padLatency)) else $error("extra padValid");

   // Readies mirror the partner valid
   assert property (@(posedge clock) seedReady == keyValid && keyReady == seedValid)
      else $error("ready rule broken");

   assert property (@(posedge clock) padValid |-> !$isunknown(pad)) else $error("pad has X bits");

endmodule

bind aesPadGen aesPadGen_checker padChecks (.*);

// File: test/aesPadGen_golden.txt
# seed (64b hex)   key (128b hex)   katFlag   lane 0 known answer (used when katFlag is 1)
# Lanes without a known answer are checked against the testbench AES model
0000000000000000 00000000000000000000000000000000 1 66e94bd4ef8a2c3b884cfa59ca342b2e
ffffffffffffffff 000102030405060708090a0b0c0d0e0f 0 0
fffffffffffffffe 2b7e151628aed2a6abf7158809cf4f3c 0 0
0123456789abcdef 2b7e151628aed2a6abf7158809cf4f3c 0 0
00000000deadbeef ffffffffffffffffffffffffffffffff 0 0
8000000000000000 00112233445566778899aabbccddeeff 0 0
0000000000000010 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0 0
7ffffffffffffffd a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a 0 0
